/* Makefile */
# Verilator build for the multicast crossbar testbench

SIM      := verilator
TOP      := tb_mcast_xbar
FILELIST := sources.f
FLAGS    := --binary --timing --timescale 1ns/1ns -j 0
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* mcast_demux.sv */
// One write in flight per initiator, mask bits outside 13:12 are ignored, addr bits 31:14 set give an error
`timescale 1ns/1ns
`default_nettype none

module mcast_demux (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  mcast_xbar_pkg::addr_t     addr_i,
  input  mcast_xbar_pkg::addr_t     mask_i,
  input  mcast_xbar_pkg::data_t     data_i,
  output logic                      rsp_valid_o,
  input  logic                      rsp_ready_i,
  output logic                      rsp_err_o,
  input  mcast_xbar_pkg::tgt_mask_t done_i,
  xbar_link_if.producer             links [mcast_xbar_pkg::NUM_TGT]
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SEND,
    ST_COMMIT,
    ST_RESPOND
  } state_e;

  state_e                                state_q;
  state_e                                state_d;
  mcast_xbar_pkg::tgt_mask_t             dec_sel;
  mcast_xbar_pkg::tgt_mask_t             send_q;
  mcast_xbar_pkg::tgt_mask_t             send_d;
  mcast_xbar_pkg::tgt_mask_t             pend_q;
  mcast_xbar_pkg::tgt_mask_t             pend_d;
  mcast_xbar_pkg::tgt_mask_t             link_vld;
  mcast_xbar_pkg::tgt_mask_t             link_hs;
  logic [mcast_xbar_pkg::TGT_SEL_W-1:0]  sel_bits;
  logic [mcast_xbar_pkg::TGT_SEL_W-1:0]  care_bits;
  logic                                  dec_err;
  logic                                  err_q;
  logic                                  req_hs;
  mcast_xbar_pkg::addr_t                 addr_q;
  mcast_xbar_pkg::data_t                 data_q;

  // A set mask bit makes the matching select bit a don't-care
  assign sel_bits  = addr_i[mcast_xbar_pkg::TGT_SEL_LSB +: mcast_xbar_pkg::TGT_SEL_W];
  assign care_bits = ~mask_i[mcast_xbar_pkg::TGT_SEL_LSB +: mcast_xbar_pkg::TGT_SEL_W];
  assign dec_err   = |addr_i[mcast_xbar_pkg::ADDR_W-1:
                             mcast_xbar_pkg::TGT_SEL_LSB + mcast_xbar_pkg::TGT_SEL_W];

  always_comb begin
    for (int j = 0; j < mcast_xbar_pkg::NUM_TGT; j++) begin
      dec_sel[j] = ((j ^ int'(sel_bits)) & int'(care_bits)) == 0;
    end
  end

  assign req_ready_o = (state_q == ST_IDLE);
  assign req_hs      = req_valid_i && req_ready_o;
  assign rsp_valid_o = (state_q == ST_RESPOND);
  assign rsp_err_o   = err_q;

  // Each selected link stays valid until its own copy is taken
  for (genvar j = 0; j < mcast_xbar_pkg::NUM_TGT; j++) begin : gen_link
    assign link_vld[j]    = (state_q == ST_SEND) && send_q[j];
    assign links[j].valid = link_vld[j];
    assign links[j].addr  = addr_q;
    assign links[j].data  = data_q;
    assign link_hs[j]     = link_vld[j] && links[j].ready;
  end

  always_comb begin
    state_d = state_q;
    send_d  = send_q & ~link_hs;
    // Done pulses may come back while other copies are still going out
    pend_d  = pend_q & ~done_i;
    unique case (state_q)
      ST_IDLE: begin
        if (req_hs) begin
          if (dec_err) begin
            state_d = ST_RESPOND;
          end else begin
            state_d = ST_SEND;
            send_d  = dec_sel;
            pend_d  = dec_sel;
          end
        end
      end
      ST_SEND: begin
        if (send_d == '0) begin
          state_d = ST_COMMIT;
        end
      end
      ST_COMMIT: begin
        if (pend_d == '0) begin
          state_d = ST_RESPOND;
        end
      end
      ST_RESPOND: begin
        if (rsp_ready_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      send_q  <= '0;
      pend_q  <= '0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      send_q  <= send_d;
      pend_q  <= pend_d;
      if (req_hs) begin
        err_q <= dec_err;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      addr_q <= addr_i;
      data_q <= data_i;
    end
  end

endmodule

`default_nettype wire

/* mcast_xbar.sv */
// Write-only multicast crossbar, each initiator gets one response after all its copies are taken
`timescale 1ns/1ns
`default_nettype none

module mcast_xbar (
  input  logic                                                 clk_i,
  input  logic                                                 rst_n_i,
  input  logic [mcast_xbar_pkg::NUM_INIT-1:0]                  init_req_valid_i,
  output logic [mcast_xbar_pkg::NUM_INIT-1:0]                  init_req_ready_o,
  input  mcast_xbar_pkg::addr_t [mcast_xbar_pkg::NUM_INIT-1:0] init_addr_i,
  input  mcast_xbar_pkg::addr_t [mcast_xbar_pkg::NUM_INIT-1:0] init_mask_i,
  input  mcast_xbar_pkg::data_t [mcast_xbar_pkg::NUM_INIT-1:0] init_data_i,
  output logic [mcast_xbar_pkg::NUM_INIT-1:0]                  init_rsp_valid_o,
  input  logic [mcast_xbar_pkg::NUM_INIT-1:0]                  init_rsp_ready_i,
  output logic [mcast_xbar_pkg::NUM_INIT-1:0]                  init_rsp_err_o,
  output logic [mcast_xbar_pkg::NUM_TGT-1:0]                   tgt_valid_o,
  input  logic [mcast_xbar_pkg::NUM_TGT-1:0]                   tgt_ready_i,
  output mcast_xbar_pkg::addr_t [mcast_xbar_pkg::NUM_TGT-1:0]  tgt_addr_o,
  output mcast_xbar_pkg::data_t [mcast_xbar_pkg::NUM_TGT-1:0]  tgt_data_o,
  output mcast_xbar_pkg::init_idx_t [mcast_xbar_pkg::NUM_TGT-1:0] tgt_src_o
);

  // Crossing signals indexed [initiator][target]
  logic [mcast_xbar_pkg::NUM_INIT-1:0][mcast_xbar_pkg::NUM_TGT-1:0] lnk_valid;
  logic [mcast_xbar_pkg::NUM_INIT-1:0][mcast_xbar_pkg::NUM_TGT-1:0] lnk_ready;
  mcast_xbar_pkg::addr_t [mcast_xbar_pkg::NUM_INIT-1:0][mcast_xbar_pkg::NUM_TGT-1:0] lnk_addr;
  mcast_xbar_pkg::data_t [mcast_xbar_pkg::NUM_INIT-1:0][mcast_xbar_pkg::NUM_TGT-1:0] lnk_data;
  // Done pulses per target, then regrouped per initiator
  logic [mcast_xbar_pkg::NUM_TGT-1:0][mcast_xbar_pkg::NUM_INIT-1:0] tgt_done;
  mcast_xbar_pkg::tgt_mask_t [mcast_xbar_pkg::NUM_INIT-1:0]          init_done;

  for (genvar i = 0; i < mcast_xbar_pkg::NUM_INIT; i++) begin : gen_init
    xbar_link_if u_link [mcast_xbar_pkg::NUM_TGT] ();

    for (genvar j = 0; j < mcast_xbar_pkg::NUM_TGT; j++) begin : gen_out
      assign lnk_valid[i][j] = u_link[j].valid;
      assign lnk_addr[i][j]  = u_link[j].addr;
      assign lnk_data[i][j]  = u_link[j].data;
      assign u_link[j].ready = lnk_ready[i][j];
      assign init_done[i][j] = tgt_done[j][i];
    end

    mcast_demux u_demux (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .req_valid_i (init_req_valid_i[i]),
      .req_ready_o (init_req_ready_o[i]),
      .addr_i      (init_addr_i[i]),
      .mask_i      (init_mask_i[i]),
      .data_i      (init_data_i[i]),
      .rsp_valid_o (init_rsp_valid_o[i]),
      .rsp_ready_i (init_rsp_ready_i[i]),
      .rsp_err_o   (init_rsp_err_o[i]),
      .done_i      (init_done[i]),
      .links       (u_link)
    );
  end

  for (genvar j = 0; j < mcast_xbar_pkg::NUM_TGT; j++) begin : gen_tgt
    xbar_link_if  u_link [mcast_xbar_pkg::NUM_INIT] ();
    xbar_entry_if u_entry ();

    for (genvar i = 0; i < mcast_xbar_pkg::NUM_INIT; i++) begin : gen_in
      assign u_link[i].valid = lnk_valid[i][j];
      assign u_link[i].addr  = lnk_addr[i][j];
      assign u_link[i].data  = lnk_data[i][j];
      assign lnk_ready[i][j] = u_link[i].ready;
    end

    target_queue u_queue (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .links   (u_link),
      .entry   (u_entry)
    );

    target_port u_port (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .entry       (u_entry),
      .tgt_valid_o (tgt_valid_o[j]),
      .tgt_ready_i (tgt_ready_i[j]),
      .tgt_addr_o  (tgt_addr_o[j]),
      .tgt_data_o  (tgt_data_o[j]),
      .tgt_src_o   (tgt_src_o[j]),
      .done_o      (tgt_done[j])
    );
  end

endmodule

`default_nettype wire

/* mcast_xbar_pkg.sv */
// Fixed sizes for 2 initiators and 4 targets in 4 KiB windows, queue depth must be a power of two
`default_nettype none

package mcast_xbar_pkg;

  // Port counts
  localparam int NUM_INIT = 2;
  localparam int NUM_TGT  = 4;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // Address map, target j owns the window starting at j * 0x1000
  localparam int TGT_SEL_LSB = 12;
  localparam int TGT_SEL_W   = 2;

  // Per-target queue sizing
  localparam int QUEUE_DEPTH = 4;
  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
  localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

  typedef logic [ADDR_W-1:0]           addr_t;
  typedef logic [DATA_W-1:0]           data_t;
  // One bit per target port
  typedef logic [NUM_TGT-1:0]          tgt_mask_t;
  typedef logic [$clog2(NUM_INIT)-1:0] init_idx_t;

endpackage

`default_nettype wire

/* sources.f */
mcast_xbar_pkg.sv
xbar_ifs.sv
mcast_demux.sv
target_queue.sv
target_port.sv
mcast_xbar.sv
tb_mcast_xbar.sv

/* target_port.sv */
// Single output register, outputs hold while tgt_ready_i is low, done pulses in the handshake cycle
`timescale 1ns/1ns
`default_nettype none

module target_port (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  xbar_entry_if.port                          entry,
  output logic                                tgt_valid_o,
  input  logic                                tgt_ready_i,
  output mcast_xbar_pkg::addr_t               tgt_addr_o,
  output mcast_xbar_pkg::data_t               tgt_data_o,
  output mcast_xbar_pkg::init_idx_t           tgt_src_o,
  output logic [mcast_xbar_pkg::NUM_INIT-1:0] done_o
);

  logic tgt_hs;
  logic load;

  assign tgt_hs = tgt_valid_o && tgt_ready_i;
  // Refill when empty or when the held entry leaves this cycle
  assign load        = !tgt_valid_o || tgt_hs;
  assign entry.ready = load;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      tgt_valid_o <= 1'b0;
    end else if (load) begin
      tgt_valid_o <= entry.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load && entry.valid) begin
      tgt_addr_o <= entry.addr;
      tgt_data_o <= entry.data;
      tgt_src_o  <= entry.src;
    end
  end

  for (genvar i = 0; i < mcast_xbar_pkg::NUM_INIT; i++) begin : gen_done
    assign done_o[i] = tgt_hs && (tgt_src_o == mcast_xbar_pkg::init_idx_t'(i));
  end

endmodule

`default_nettype wire

/* target_queue.sv */
// Round-robin over initiators, a grant needs a free slot, so a full queue stalls every link
`timescale 1ns/1ns
`default_nettype none

module target_queue (
  input  logic        clk_i,
  input  logic        rst_n_i,
  xbar_link_if.queue  links [mcast_xbar_pkg::NUM_INIT],
  xbar_entry_if.queue entry
);

  logic [mcast_xbar_pkg::NUM_INIT-1:0]    req_vld;
  mcast_xbar_pkg::addr_t                  req_addr [mcast_xbar_pkg::NUM_INIT];
  mcast_xbar_pkg::data_t                  req_data [mcast_xbar_pkg::NUM_INIT];
  mcast_xbar_pkg::init_idx_t              rr_q;
  mcast_xbar_pkg::init_idx_t              rr_nxt;
  mcast_xbar_pkg::init_idx_t              gnt_idx;
  logic                                   gnt_vld;
  logic                                   full;
  logic                                   push;
  logic                                   pop;
  logic [mcast_xbar_pkg::QUEUE_PTR_W-1:0] wr_ptr_q;
  logic [mcast_xbar_pkg::QUEUE_PTR_W-1:0] rd_ptr_q;
  logic [mcast_xbar_pkg::QUEUE_CNT_W-1:0] cnt_q;
  mcast_xbar_pkg::addr_t                  mem_addr [mcast_xbar_pkg::QUEUE_DEPTH];
  mcast_xbar_pkg::data_t                  mem_data [mcast_xbar_pkg::QUEUE_DEPTH];
  mcast_xbar_pkg::init_idx_t              mem_src  [mcast_xbar_pkg::QUEUE_DEPTH];

  for (genvar i = 0; i < mcast_xbar_pkg::NUM_INIT; i++) begin : gen_link
    assign req_vld[i]     = links[i].valid;
    assign req_addr[i]    = links[i].addr;
    assign req_data[i]    = links[i].data;
    // Only the winner sees ready
    assign links[i].ready = push && (gnt_idx == mcast_xbar_pkg::init_idx_t'(i));
  end

  // Search starts at the pointer, first valid link wins
  always_comb begin
    int unsigned idx;
    gnt_vld = 1'b0;
    gnt_idx = rr_q;
    for (int k = 0; k < mcast_xbar_pkg::NUM_INIT; k++) begin
      idx = (int'(rr_q) + k) % mcast_xbar_pkg::NUM_INIT;
      if (!gnt_vld && req_vld[idx]) begin
        gnt_vld = 1'b1;
        gnt_idx = mcast_xbar_pkg::init_idx_t'(idx);
      end
    end
  end

  assign rr_nxt = mcast_xbar_pkg::init_idx_t'((int'(gnt_idx) + 1) % mcast_xbar_pkg::NUM_INIT);
  assign full   = (cnt_q == mcast_xbar_pkg::QUEUE_DEPTH);
  assign push   = gnt_vld && !full;
  assign pop    = entry.valid && entry.ready;

  assign entry.valid = (cnt_q != '0);
  assign entry.addr  = mem_addr[rd_ptr_q];
  assign entry.data  = mem_data[rd_ptr_q];
  assign entry.src   = mem_src[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_q     <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
        rr_q     <= rr_nxt;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_addr[wr_ptr_q] <= req_addr[gnt_idx];
      mem_data[wr_ptr_q] <= req_data[gnt_idx];
      mem_src[wr_ptr_q]  <= gnt_idx;
    end
  end

endmodule

`default_nettype wire

/* tb_mcast_xbar.sv */
// Response ready held high, targets stall at random, a row flagged both is paired with the next row
`timescale 1ns/1ns
`default_nettype none

module tb_mcast_xbar;

  logic                                                  clk = 1'b0;
  logic                                                  rst_n;
  logic [mcast_xbar_pkg::NUM_INIT-1:0]                   req_valid;
  logic [mcast_xbar_pkg::NUM_INIT-1:0]                   req_ready;
  mcast_xbar_pkg::addr_t [mcast_xbar_pkg::NUM_INIT-1:0]  req_addr;
  mcast_xbar_pkg::addr_t [mcast_xbar_pkg::NUM_INIT-1:0]  req_mask;
  mcast_xbar_pkg::data_t [mcast_xbar_pkg::NUM_INIT-1:0]  req_data;
  logic [mcast_xbar_pkg::NUM_INIT-1:0]                   rsp_valid;
  logic [mcast_xbar_pkg::NUM_INIT-1:0]                   rsp_ready;
  logic [mcast_xbar_pkg::NUM_INIT-1:0]                   rsp_err;
  logic [mcast_xbar_pkg::NUM_TGT-1:0]                    tgt_valid;
  logic [mcast_xbar_pkg::NUM_TGT-1:0]                    tgt_ready;
  mcast_xbar_pkg::addr_t [mcast_xbar_pkg::NUM_TGT-1:0]   tgt_addr;
  mcast_xbar_pkg::data_t [mcast_xbar_pkg::NUM_TGT-1:0]   tgt_data;
  mcast_xbar_pkg::init_idx_t [mcast_xbar_pkg::NUM_TGT-1:0] tgt_src;

  // Stimulus table, one entry per row
  int unsigned           row_init [$];
  mcast_xbar_pkg::addr_t row_addr [$];
  mcast_xbar_pkg::addr_t row_mask [$];
  mcast_xbar_pkg::data_t row_data [$];
  logic                  row_both [$];
  logic                  row_err  [$];

  // Expected {addr, data} per target and source initiator
  logic [63:0] exp_q [mcast_xbar_pkg::NUM_TGT][mcast_xbar_pkg::NUM_INIT][$];
  int unsigned exp_rsp  [mcast_xbar_pkg::NUM_INIT];
  int unsigned rsp_seen [mcast_xbar_pkg::NUM_INIT];
  int unsigned cycles;
  int unsigned cycle_limit;
  integer      seed = 32'hbb4f;

  mcast_xbar u_dut (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .init_req_valid_i (req_valid),
    .init_req_ready_o (req_ready),
    .init_addr_i      (req_addr),
    .init_mask_i      (req_mask),
    .init_data_i      (req_data),
    .init_rsp_valid_o (rsp_valid),
    .init_rsp_ready_i (rsp_ready),
    .init_rsp_err_o   (rsp_err),
    .tgt_valid_o      (tgt_valid),
    .tgt_ready_i      (tgt_ready),
    .tgt_addr_o       (tgt_addr),
    .tgt_data_o       (tgt_data),
    .tgt_src_o        (tgt_src)
  );

  always #50 clk = ~clk;

  task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s, got %h expected %h", $time, what, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic add_row(input int unsigned init, input mcast_xbar_pkg::addr_t addr,
                         input mcast_xbar_pkg::addr_t mask, input mcast_xbar_pkg::data_t data,
                         input logic both, input logic err);
    row_init.push_back(init);
    row_addr.push_back(addr);
    row_mask.push_back(mask);
    row_data.push_back(data);
    row_both.push_back(both);
    row_err.push_back(err);
  endtask

  // Target j matches when every select bit not masked equals bit of j
  function automatic mcast_xbar_pkg::tgt_mask_t expected_targets(
      input mcast_xbar_pkg::addr_t addr, input mcast_xbar_pkg::addr_t mask);
    mcast_xbar_pkg::tgt_mask_t hit;
    int unsigned               pos;
    hit = '0;
    if (addr[31:14] == '0) begin
      for (int j = 0; j < mcast_xbar_pkg::NUM_TGT; j++) begin
        hit[j] = 1'b1;
        for (int b = 0; b < mcast_xbar_pkg::TGT_SEL_W; b++) begin
          pos = mcast_xbar_pkg::TGT_SEL_LSB + b;
          if (!mask[pos] && (addr[pos] != ((j >> b) & 1))) begin
            hit[j] = 1'b0;
          end
        end
      end
    end
    return hit;
  endfunction

  task automatic run_write(input int unsigned r);
    int unsigned               i;
    mcast_xbar_pkg::tgt_mask_t hit;
    i   = row_init[r];
    hit = expected_targets(row_addr[r], row_mask[r]);
    for (int j = 0; j < mcast_xbar_pkg::NUM_TGT; j++) begin
      if (hit[j]) begin
        exp_q[j][i].push_back({row_addr[r], row_data[r]});
      end
    end
    exp_rsp[i]++;
    @(posedge clk);
    req_valid[i] <= 1'b1;
    req_addr[i]  <= row_addr[r];
    req_mask[i]  <= row_mask[r];
    req_data[i]  <= row_data[r];
    @(negedge clk);
    while (!req_ready[i]) @(negedge clk);
    // Handshake happens on this edge, valid drops right after
    @(posedge clk);
    req_valid[i] <= 1'b0;
    @(negedge clk);
    while (!rsp_valid[i]) @(negedge clk);
    check_val(64'(rsp_err[i]), 64'(row_err[r]), $sformatf("row %0d response error bit", r));
    // Every copy must have been taken before the response
    for (int j = 0; j < mcast_xbar_pkg::NUM_TGT; j++) begin
      check_val(64'(exp_q[j][i].size()), 64'd0,
                $sformatf("row %0d copies pending at target %0d on response", r, j));
    end
  endtask

  task automatic take_delivery(input int j);
    int unsigned s;
    s = tgt_src[j];
    if (exp_q[j][s].size() == 0) begin
      $display("Unexpected write at target %0d from initiator %0d at %0t", j, s, $time);
      $display("TEST RESULT: FAIL");
      $fatal(1, "unexpected write");
    end else begin
      check_val({tgt_addr[j], tgt_data[j]}, exp_q[j][s].pop_front(),
                $sformatf("target %0d write from initiator %0d", j, s));
    end
  endtask

  // Random target back-pressure
  always @(posedge clk) begin
    tgt_ready <= mcast_xbar_pkg::tgt_mask_t'($random(seed));
  end

  // Handshakes are sampled at the falling edge where everything is settled
  always @(negedge clk) begin
    if (rst_n) begin
      for (int j = 0; j < mcast_xbar_pkg::NUM_TGT; j++) begin
        if (tgt_valid[j] && tgt_ready[j]) begin
          take_delivery(j);
        end
      end
      for (int i = 0; i < mcast_xbar_pkg::NUM_INIT; i++) begin
        if (rsp_valid[i] && rsp_ready[i]) begin
          rsp_seen[i]++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      $display("The run timed out after %0d cycles", cycles);
      $display("TEST RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  initial begin
    int unsigned r;
    int unsigned left;
    rst_n       = 1'b0;
    req_valid   = '0;
    req_addr    = '0;
    req_mask    = '0;
    req_data    = '0;
    rsp_ready   = '1;
    tgt_ready   = '0;
    cycles      = 0;
    cycle_limit = 0;
    for (int i = 0; i < mcast_xbar_pkg::NUM_INIT; i++) begin
      exp_rsp[i]  = 0;
      rsp_seen[i] = 0;
    end
    // Unicast, multicast, decode errors, ignored mask bits
    add_row(0, 32'h0000_0010, 32'h0000_0000, 32'h1111_0001, 1'b0, 1'b0);
    add_row(1, 32'h0000_2020, 32'h0000_0000, 32'h1111_0002, 1'b0, 1'b0);
    add_row(0, 32'h0000_3004, 32'h0000_3000, 32'h2222_0003, 1'b0, 1'b0);
    add_row(1, 32'h0000_1008, 32'h0000_1000, 32'h2222_0004, 1'b0, 1'b0);
    add_row(0, 32'h0000_2000, 32'h0000_2000, 32'h2222_0005, 1'b0, 1'b0);
    add_row(0, 32'h0000_4000, 32'h0000_0000, 32'h3333_0006, 1'b0, 1'b1);
    add_row(1, 32'h8000_1000, 32'h0000_3000, 32'h3333_0007, 1'b0, 1'b1);
    add_row(0, 32'h0000_1100, 32'hffff_cfff, 32'h4444_0008, 1'b0, 1'b0);
    // Both initiators at once, same target then overlapping multicast
    add_row(0, 32'h0000_1200, 32'h0000_0000, 32'h5555_0009, 1'b1, 1'b0);
    add_row(1, 32'h0000_1204, 32'h0000_0000, 32'h5555_000a, 1'b0, 1'b0);
    add_row(0, 32'h0000_3000, 32'h0000_3000, 32'h5555_000b, 1'b1, 1'b0);
    add_row(1, 32'h0000_2000, 32'h0000_1000, 32'h5555_000c, 1'b0, 1'b0);
    // Back-to-back writes for ordering under back-pressure
    add_row(0, 32'h0000_3010, 32'h0000_0000, 32'h6666_000d, 1'b1, 1'b0);
    add_row(1, 32'h0000_3014, 32'h0000_2000, 32'h6666_000e, 1'b0, 1'b0);
    add_row(0, 32'h0000_3018, 32'h0000_1000, 32'h6666_000f, 1'b1, 1'b0);
    add_row(1, 32'h0000_301c, 32'h0000_3000, 32'h6666_0010, 1'b0, 1'b0);
    cycle_limit = 40 * (row_addr.size() + 1);
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    r = 0;
    while (r < row_addr.size()) begin
      if (row_both[r]) begin
        fork
          run_write(r);
          run_write(r + 1);
        join
        r = r + 2;
      end else begin
        run_write(r);
        r = r + 1;
      end
    end
    repeat (10) @(posedge clk);
    for (int i = 0; i < mcast_xbar_pkg::NUM_INIT; i++) begin
      check_val(64'(rsp_seen[i]), 64'(exp_rsp[i]), $sformatf("initiator %0d responses", i));
    end
    left = 0;
    for (int j = 0; j < mcast_xbar_pkg::NUM_TGT; j++) begin
      for (int i = 0; i < mcast_xbar_pkg::NUM_INIT; i++) begin
        left = left + exp_q[j][i].size();
      end
    end
    if (left == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("%0d expected writes never reached their targets", left);
      $display("TEST RESULT: FAIL");
      $fatal(1, "missing writes");
    end
  end

endmodule

`default_nettype wire

/* xbar_ifs.sv */
// Internal valid/ready channels, payload must stay stable while valid is high and ready is low
`timescale 1ns/1ns
`default_nettype none

// One write copy from a demux to a target queue
interface xbar_link_if;
  logic                  valid;
  logic                  ready;
  mcast_xbar_pkg::addr_t addr;
  mcast_xbar_pkg::data_t data;

  modport producer (
    output valid,
    output addr,
    output data,
    input  ready
  );

  modport queue (
    input  valid,
    input  addr,
    input  data,
    output ready
  );
endinterface

// Oldest queued write, tagged with its source initiator
interface xbar_entry_if;
  logic                      valid;
  logic                      ready;
  mcast_xbar_pkg::addr_t     addr;
  mcast_xbar_pkg::data_t     data;
  mcast_xbar_pkg::init_idx_t src;

  modport queue (
    output valid,
    output addr,
    output data,
    output src,
    input  ready
  );

  modport port (
    input  valid,
    input  addr,
    input  data,
    input  src,
    output ready
  );
endinterface

`default_nettype wire
